/* design/mul_defines.svh */
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// Datapath widths.
`define MUL_XLEN    64
`define MUL_PROD_W  128
`define MUL_EXT_W   66
`define MUL_PP_NUM  33

// Core identifiers.
`define MUL_IID_W   5
`define MUL_PREG_W  6

// Major opcodes of the register-register multiply forms.
`define MUL_OPC_OP    7'b0110011
`define MUL_OPC_OP32  7'b0111011

`endif

/* design/mul_pkg.sv */
`default_nettype none

`include "mul_defines.svh"

package mul_pkg;

    typedef struct packed {
        logic                   vld;
        logic [`MUL_IID_W-1:0]  iid;
        logic [6:0]             opcode;
        logic [2:0]             funct3;
        logic [`MUL_XLEN-1:0]   src1;
        logic [`MUL_XLEN-1:0]   src2;
        logic [`MUL_PREG_W-1:0] pdst;
    } mul_issue_t;

    // Follows the data down every stage.
    typedef struct packed {
        logic [`MUL_IID_W-1:0]  iid;
        logic                   op64;
        logic [2:0]             funct3;
        logic [`MUL_PREG_W-1:0] pdst;
    } mul_tag_t;

    typedef struct packed {
        mul_tag_t              tag;
        logic [`MUL_EXT_W-1:0] src1_ext;
        logic [`MUL_EXT_W-1:0] src2_ext;
    } mul_ext_t;

    typedef struct packed {
        mul_tag_t                                   tag;
        logic [`MUL_PP_NUM-1:0][`MUL_PROD_W-1:0]    pp;
    } mul_pp_t;

    typedef struct packed {
        mul_tag_t               tag;
        logic [`MUL_PROD_W-1:0] sum;
        logic [`MUL_PROD_W-1:0] carry;
    } mul_tree_t;

    typedef struct packed {
        mul_tag_t             tag;
        logic [`MUL_XLEN-1:0] sum_h;
        logic [`MUL_XLEN-1:0] carry_h;
        logic [`MUL_XLEN-1:0] res_l;
        logic                 cout;
    } mul_low_t;

    typedef struct packed {
        mul_tag_t             tag;
        logic [`MUL_XLEN-1:0] res_l;
        logic [`MUL_XLEN-1:0] res_h;
    } mul_high_t;

    typedef struct packed {
        logic                   vld;
        logic [`MUL_PREG_W-1:0] preg;
        logic [`MUL_XLEN-1:0]   data;
    } mul_wb_t;

    typedef struct packed {
        logic                   vld;
        logic [`MUL_PREG_W-1:0] preg;
    } mul_fwd_t;

endpackage

`default_nettype wire

/* design/mul_stage_reg.sv */
`default_nettype none

module mul_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_clk,
    input  logic     flush,
    input  logic     in_vld,
    input  payload_t in_data,
    output logic     out_vld,
    output payload_t out_data
);

    always_ff @(posedge clk or negedge rst_clk) begin
        if (!rst_clk) begin
            out_vld <= 1'b0;
        end else begin
            out_vld <= in_vld & ~flush;
        end
    end

    // Bubbles and flushed slots carry zeros.
    always_ff @(posedge clk) begin
        if (flush || !in_vld) begin
            out_data <= '0;
        end else begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

/* design/mul_operand_stage.sv */
`default_nettype none

`include "mul_defines.svh"

module mul_operand_stage (
    input  logic                 clk,
    input  logic                 rst_clk,
    input  logic                 flush,
    input  mul_pkg::mul_issue_t  issue,
    output logic                 out_vld,
    output mul_pkg::mul_ext_t    out_data
);

    localparam int HALF = `MUL_XLEN / 2;
    localparam int PAD  = `MUL_EXT_W - `MUL_XLEN;

    logic                 accept;
    logic                 op64;
    logic                 sign1;
    logic                 sign2;
    logic [`MUL_XLEN-1:0] opa;
    logic [`MUL_XLEN-1:0] opb;
    mul_pkg::mul_ext_t    ext_d;

    // Divide encodings share the opcode and are dropped here.
    assign accept = issue.vld & ~issue.funct3[2];
    assign op64   = (issue.opcode == `MUL_OPC_OP);

    // Word forms use the sign-extended low halves.
    assign opa = op64 ? issue.src1 : {{HALF{issue.src1[HALF-1]}}, issue.src1[HALF-1:0]};
    assign opb = op64 ? issue.src2 : {{HALF{issue.src2[HALF-1]}}, issue.src2[HALF-1:0]};

    // MULHU is unsigned on both sides, MULHSU only on the second.
    assign sign1 = (issue.funct3[1:0] != 2'b11);
    assign sign2 = ~issue.funct3[1];

    always_comb begin
        ext_d.tag.iid    = issue.iid;
        ext_d.tag.op64   = op64;
        ext_d.tag.funct3 = issue.funct3;
        ext_d.tag.pdst   = issue.pdst;
        ext_d.src1_ext   = {{PAD{sign1 & opa[`MUL_XLEN-1]}}, opa};
        ext_d.src2_ext   = {{PAD{sign2 & opb[`MUL_XLEN-1]}}, opb};
    end

    mul_stage_reg #(.payload_t(mul_pkg::mul_ext_t)) u_reg (
        .clk      (clk),
        .rst_clk  (rst_clk),
        .flush    (flush),
        .in_vld   (accept),
        .in_data  (ext_d),
        .out_vld  (out_vld),
        .out_data (out_data)
    );

endmodule

`default_nettype wire

/* design/mul_booth_stage.sv */
`default_nettype none

`include "mul_defines.svh"

module mul_booth_stage (
    input  logic              clk,
    input  logic              rst_clk,
    input  logic              flush,
    input  logic              in_vld,
    input  mul_pkg::mul_ext_t in_data,
    output logic              out_vld,
    output mul_pkg::mul_pp_t  out_data
);

    localparam int PW = `MUL_PROD_W;

    logic [PW-1:0]          x_sx;
    logic [`MUL_EXT_W:0]    y_pad;
    mul_pkg::mul_pp_t       pp_d;

    // Multiplicand widened to the product, multiplier with the implicit zero below bit 0.
    assign x_sx  = {{(PW - `MUL_EXT_W){in_data.src1_ext[`MUL_EXT_W-1]}}, in_data.src1_ext};
    assign y_pad = {in_data.src2_ext, 1'b0};

    always_comb begin
        logic [2:0]    grp;
        logic [PW-1:0] mult;
        pp_d.tag = in_data.tag;
        for (int i = 0; i < `MUL_PP_NUM; i++) begin
            grp = y_pad[2*i +: 3];
            case (grp)
                3'b001, 3'b010: mult = x_sx;
                3'b011:         mult = x_sx << 1;
                3'b100:         mult = -(x_sx << 1);
                3'b101, 3'b110: mult = -x_sx;
                default:        mult = '0;
            endcase
            // Row weight is 4^i.
            pp_d.pp[i] = mult << (2 * i);
        end
    end

    mul_stage_reg #(.payload_t(mul_pkg::mul_pp_t)) u_reg (
        .clk      (clk),
        .rst_clk  (rst_clk),
        .flush    (flush),
        .in_vld   (in_vld),
        .in_data  (pp_d),
        .out_vld  (out_vld),
        .out_data (out_data)
    );

endmodule

`default_nettype wire

/* design/mul_csa_tree_stage.sv */
`default_nettype none

`include "mul_defines.svh"

module mul_csa_tree_stage (
    input  logic               clk,
    input  logic               rst_clk,
    input  logic               flush,
    input  logic               in_vld,
    input  mul_pkg::mul_pp_t   in_data,
    output logic               out_vld,
    output mul_pkg::mul_tree_t out_data,
    output mul_pkg::mul_fwd_t  fwd1
);

    localparam int PW  = `MUL_PROD_W;
    localparam int NUM = `MUL_PP_NUM;

    // Rows left after a given number of 3:2 levels.
    function automatic int rows_at(input int lvl);
        int n;
        n = NUM;
        for (int l = 0; l < lvl; l++) begin
            n = (n / 3) * 2 + n % 3;
        end
        return n;
    endfunction

    function automatic int levels_needed();
        int l;
        l = 0;
        while (rows_at(l) > 2) begin
            l++;
        end
        return l;
    endfunction

    localparam int LVLS = levels_needed();

    logic [PW-1:0]      rows [LVLS+1][NUM];
    mul_pkg::mul_tree_t tree_d;

    for (genvar r = 0; r < NUM; r++) begin : g_in
        assign rows[0][r] = in_data.pp[r];
    end

    for (genvar l = 0; l < LVLS; l++) begin : g_lvl
        localparam int N_IN  = rows_at(l);
        localparam int N_GRP = N_IN / 3;
        localparam int N_OUT = rows_at(l + 1);

        for (genvar g = 0; g < N_GRP; g++) begin : g_csa
            assign rows[l+1][2*g] = rows[l][3*g] ^ rows[l][3*g+1] ^ rows[l][3*g+2];
            assign rows[l+1][2*g+1] = ((rows[l][3*g] & rows[l][3*g+1]) |
                                       (rows[l][3*g] & rows[l][3*g+2]) |
                                       (rows[l][3*g+1] & rows[l][3*g+2])) << 1;
        end
        // Leftover rows skip this level.
        for (genvar r = 0; r < N_IN % 3; r++) begin : g_pass
            assign rows[l+1][2*N_GRP+r] = rows[l][3*N_GRP+r];
        end
        for (genvar r = N_OUT; r < NUM; r++) begin : g_zero
            assign rows[l+1][r] = '0;
        end
    end

    assign tree_d.tag   = in_data.tag;
    assign tree_d.sum   = rows[LVLS][0];
    assign tree_d.carry = rows[LVLS][1];

    mul_stage_reg #(.payload_t(mul_pkg::mul_tree_t)) u_reg (
        .clk      (clk),
        .rst_clk  (rst_clk),
        .flush    (flush),
        .in_vld   (in_vld),
        .in_data  (tree_d),
        .out_vld  (out_vld),
        .out_data (out_data)
    );

    // First early wake-up, two cycles ahead of writeback.
    assign fwd1.vld  = out_vld & (out_data.tag.pdst != '0);
    assign fwd1.preg = out_data.tag.pdst;

endmodule

`default_nettype wire

/* design/mul_final_add_stage.sv */
`default_nettype none

`include "mul_defines.svh"

module mul_final_add_stage (
    input  logic                   clk,
    input  logic                   rst_clk,
    input  logic                   flush,
    input  logic                   in_vld,
    input  mul_pkg::mul_tree_t     in_data,
    output logic                   complete,
    output logic [`MUL_IID_W-1:0]  complete_iid,
    output mul_pkg::mul_wb_t       wb,
    output mul_pkg::mul_fwd_t      fwd2
);

    localparam int XL   = `MUL_XLEN;
    localparam int HALF = `MUL_XLEN / 2;

    logic               low_vld;
    logic               high_vld;
    mul_pkg::mul_low_t  low_d;
    mul_pkg::mul_low_t  low_q;
    mul_pkg::mul_high_t high_d;
    mul_pkg::mul_high_t high_q;
    logic [XL-1:0]      res_sel;

    // Low half first, carry kept for the next cycle.
    always_comb begin
        low_d.tag                 = in_data.tag;
        low_d.sum_h               = in_data.sum[2*XL-1:XL];
        low_d.carry_h             = in_data.carry[2*XL-1:XL];
        {low_d.cout, low_d.res_l} = {1'b0, in_data.sum[XL-1:0]} +
                                    {1'b0, in_data.carry[XL-1:0]};
    end

    mul_stage_reg #(.payload_t(mul_pkg::mul_low_t)) u_low_reg (
        .clk      (clk),
        .rst_clk  (rst_clk),
        .flush    (flush),
        .in_vld   (in_vld),
        .in_data  (low_d),
        .out_vld  (low_vld),
        .out_data (low_q)
    );

    assign high_d.tag   = low_q.tag;
    assign high_d.res_l = low_q.res_l;
    assign high_d.res_h = low_q.sum_h + low_q.carry_h + XL'(low_q.cout);

    mul_stage_reg #(.payload_t(mul_pkg::mul_high_t)) u_high_reg (
        .clk      (clk),
        .rst_clk  (rst_clk),
        .flush    (flush),
        .in_vld   (low_vld),
        .in_data  (high_d),
        .out_vld  (high_vld),
        .out_data (high_q)
    );

    // MUL and MULW take the low half.
    assign res_sel = (high_q.tag.funct3[1:0] == 2'b00) ? high_q.res_l : high_q.res_h;

    assign complete     = high_vld;
    assign complete_iid = high_q.tag.iid;

    assign wb.vld  = high_vld & (high_q.tag.pdst != '0);
    assign wb.preg = high_q.tag.pdst;
    assign wb.data = high_q.tag.op64 ? res_sel : {{HALF{res_sel[HALF-1]}}, res_sel[HALF-1:0]};

    assign fwd2.vld  = low_vld & (low_q.tag.pdst != '0);
    assign fwd2.preg = low_q.tag.pdst;

endmodule

`default_nettype wire

/* design/mul_top.sv */
`default_nettype none

`include "mul_defines.svh"

module mul_top (
    input  logic                   clk,
    input  logic                   rst_clk,
    input  logic                   flush,
    input  mul_pkg::mul_issue_t    issue,
    output logic                   complete,
    output logic [`MUL_IID_W-1:0]  complete_iid,
    output mul_pkg::mul_wb_t       wb,
    output mul_pkg::mul_fwd_t      fwd1,
    output mul_pkg::mul_fwd_t      fwd2
);

    logic               ext_vld;
    mul_pkg::mul_ext_t  ext_data;
    logic               pp_vld;
    mul_pkg::mul_pp_t   pp_data;
    logic               tree_vld;
    mul_pkg::mul_tree_t tree_data;

    mul_operand_stage u_operand (
        .clk      (clk),
        .rst_clk  (rst_clk),
        .flush    (flush),
        .issue    (issue),
        .out_vld  (ext_vld),
        .out_data (ext_data)
    );

    mul_booth_stage u_booth (
        .clk      (clk),
        .rst_clk  (rst_clk),
        .flush    (flush),
        .in_vld   (ext_vld),
        .in_data  (ext_data),
        .out_vld  (pp_vld),
        .out_data (pp_data)
    );

    mul_csa_tree_stage u_tree (
        .clk      (clk),
        .rst_clk  (rst_clk),
        .flush    (flush),
        .in_vld   (pp_vld),
        .in_data  (pp_data),
        .out_vld  (tree_vld),
        .out_data (tree_data),
        .fwd1     (fwd1)
    );

    mul_final_add_stage u_final (
        .clk          (clk),
        .rst_clk      (rst_clk),
        .flush        (flush),
        .in_vld       (tree_vld),
        .in_data      (tree_data),
        .complete     (complete),
        .complete_iid (complete_iid),
        .wb           (wb),
        .fwd2         (fwd2)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period.
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge.
    initial begin
        rst_clk = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_clk = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/tb_mul_top.sv */
`default_nettype none

`include "mul_defines.svh"

module tb_mul_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int XL      = `MUL_XLEN;
    localparam int HALF    = `MUL_XLEN / 2;
    localparam int DEPTH   = 5;
    localparam int TIMEOUT = 200;

    localparam logic [XL-1:0] CORNERS [6] = '{
        64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001, 64'hFFFF_FFFF_FFFF_FFFF,
        64'h8000_0000_0000_0000, 64'h7FFF_FFFF_FFFF_FFFF, 64'h0000_0000_FFFF_FFFF
    };
    localparam logic [HALF-1:0] W_CORNERS [5] = '{
        32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF
    };

    // One expected completion.
    typedef struct packed {
        logic [`MUL_IID_W-1:0]  iid;
        logic                   wb_vld;
        logic [`MUL_PREG_W-1:0] preg;
        logic [XL-1:0]          data;
    } exp_t;

    logic                  clk;
    logic                  rst_clk;
    logic                  flush;
    mul_pkg::mul_issue_t   issue;
    logic                  complete;
    logic [`MUL_IID_W-1:0] complete_iid;
    mul_pkg::mul_wb_t      wb;
    mul_pkg::mul_fwd_t     fwd1;
    mul_pkg::mul_fwd_t     fwd2;

    exp_t                  exp_q [$];
    exp_t                  cur;
    logic                  cur_vld = 1'b0;
    int                    cyc = 0;
    int                    cmp_count = 0;
    int                    cmp_cyc = -1;
    int                    fwd1_cyc = -1;
    int                    fwd2_cyc = -1;
    int                    errors = 0;
    int                    tests = 0;
    logic                  hung = 1'b0;
    string                 hang_msg;
    logic [63:0]           lcg_state;
    logic [`MUL_IID_W-1:0] next_iid;

    tb_clock_gen u_clk (
        .clk     (clk),
        .rst_clk (rst_clk)
    );

    mul_top dut (
        .clk          (clk),
        .rst_clk      (rst_clk),
        .flush        (flush),
        .issue        (issue),
        .complete     (complete),
        .complete_iid (complete_iid),
        .wb           (wb),
        .fwd1         (fwd1),
        .fwd2         (fwd2)
    );

    function automatic logic [63:0] lcg_next();
        lcg_state = lcg_state * 64'h5851_F42D_4C95_7F2D + 64'h1405_7B7E_F767_814F;
        return lcg_state;
    endfunction

    function automatic logic [XL-1:0] garbage_hi(input logic [HALF-1:0] lo);
        logic [XL-1:0] r;
        r = lcg_next();
        return {r[XL-1:HALF], lo};
    endfunction

    // Full 128-bit products, signedness per instruction.
    function automatic logic [XL-1:0] ref_result(input logic op64, input logic [2:0] f3,
                                                 input logic [XL-1:0] a,
                                                 input logic [XL-1:0] b);
        logic [2*XL-1:0] sa;
        logic [2*XL-1:0] sb;
        logic [2*XL-1:0] ub;
        logic [2*XL-1:0] prod;
        logic [XL-1:0]   word;
        if (!op64) begin
            word = {{HALF{a[HALF-1]}}, a[HALF-1:0]} * {{HALF{b[HALF-1]}}, b[HALF-1:0]};
            return {{HALF{word[HALF-1]}}, word[HALF-1:0]};
        end
        sa = {{XL{a[XL-1]}}, a};
        sb = {{XL{b[XL-1]}}, b};
        ub = {{XL{1'b0}}, b};
        case (f3[1:0])
            2'b00, 2'b01: prod = sa * sb;
            2'b10:        prod = sa * ub;
            default:      prod = {{XL{1'b0}}, a} * ub;
        endcase
        return (f3[1:0] == 2'b00) ? prod[XL-1:0] : prod[2*XL-1:XL];
    endfunction

    function automatic void report_fail(input string msg);
        errors++;
        $display("FAIL %0d ns: %s", $time, msg);
    endfunction

    function automatic void check(input logic cond, input string msg);
        assert (cond) else report_fail(msg);
    endfunction

    // Accepted ops enter the expected queue at the edge that samples them.
    always @(posedge clk) begin
        exp_t e;
        cyc++;
        if (flush) begin
            exp_q.delete();
        end else if (issue.vld && !issue.funct3[2]) begin
            e.iid    = issue.iid;
            e.wb_vld = (issue.pdst != '0);
            e.preg   = issue.pdst;
            e.data   = ref_result(issue.opcode == `MUL_OPC_OP, issue.funct3,
                                  issue.src1, issue.src2);
            exp_q.push_back(e);
        end
    end

    // Outputs are stable here, half a cycle after they change.
    always @(negedge clk) begin
        cur_vld = 1'b0;
        if (complete) begin
            cmp_count++;
            cmp_cyc = cyc;
            if (exp_q.size() > 0) begin
                cur     = exp_q.pop_front();
                cur_vld = 1'b1;
            end
        end
        if (fwd1.vld) begin
            fwd1_cyc = cyc;
        end
        if (fwd2.vld) begin
            fwd2_cyc = cyc;
        end
    end

    a_order: assert property (@(posedge clk) disable iff (!rst_clk)
        complete |-> cur_vld && complete_iid == cur.iid)
        else report_fail("completion with no matching op or iid out of order");

    a_wb_vld: assert property (@(posedge clk) disable iff (!rst_clk)
        complete |-> wb.vld == cur.wb_vld)
        else report_fail("writeback valid wrong for destination register");

    a_wb_data: assert property (@(posedge clk) disable iff (!rst_clk)
        wb.vld |-> complete && cur_vld && wb.preg == cur.preg && wb.data == cur.data)
        else report_fail("writeback register or data differs from the product");

    a_fwd2: assert property (@(posedge clk) disable iff (!rst_clk)
        fwd2.vld |-> $past(fwd1.vld) && fwd2.preg == $past(fwd1.preg))
        else report_fail("fwd2 without fwd1 one cycle earlier");

    a_fwd_wb: assert property (@(posedge clk) disable iff (!rst_clk)
        wb.vld |-> $past(fwd2.vld) && wb.preg == $past(fwd2.preg))
        else report_fail("writeback without fwd2 one cycle earlier");

    task automatic send(input logic op64, input logic [2:0] f3, input logic [XL-1:0] a,
                        input logic [XL-1:0] b, input logic [`MUL_PREG_W-1:0] pdst);
        @(negedge clk);
        issue.vld    = 1'b1;
        issue.iid    = next_iid;
        issue.opcode = op64 ? `MUL_OPC_OP : `MUL_OPC_OP32;
        issue.funct3 = f3;
        issue.src1   = a;
        issue.src2   = b;
        issue.pdst   = pdst;
        next_iid++;
    endtask

    task automatic idle();
        @(negedge clk);
        issue = '0;
        flush = 1'b0;
    endtask

    task automatic drain();
        int n;
        idle();
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0 && !hung) begin
            hung     = 1'b1;
            hang_msg = "expected results never arrived, pipeline did not drain";
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests++;
        $display("%s: %0d errors", name, errors - err_start);
    endtask

    task automatic mul_random_corners();
        int e0;
        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) begin
                send(1'b1, 3'b000, CORNERS[i], CORNERS[j], 6'(i * 6 + j + 1));
            end
        end
        for (int i = 0; i < 40; i++) begin
            send(1'b1, 3'b000, lcg_next(), lcg_next(), 6'(i % 63 + 1));
        end
        drain();
        finish_test("mul random and corners", e0);
    endtask

    task automatic mulh_signedness();
        int e0;
        e0 = errors;
        for (int f = 1; f < 4; f++) begin
            for (int i = 0; i < 36; i++) begin
                send(1'b1, 3'(f), CORNERS[i / 6], CORNERS[i % 6], 6'(i + 1));
            end
            for (int i = 0; i < 20; i++) begin
                send(1'b1, 3'(f), lcg_next(), lcg_next(), 6'(i + 40));
            end
        end
        drain();
        finish_test("mulh mulhsu mulhu", e0);
    endtask

    task automatic mulw_upper_garbage();
        int e0;
        e0 = errors;
        for (int i = 0; i < 25; i++) begin
            send(1'b0, 3'b000, garbage_hi(W_CORNERS[i / 5]), garbage_hi(W_CORNERS[i % 5]),
                 6'(i + 1));
        end
        for (int i = 0; i < 30; i++) begin
            send(1'b0, 3'b000, lcg_next(), lcg_next(), 6'(i + 30));
        end
        drain();
        finish_test("mulw upper garbage", e0);
    endtask

    task automatic single_op_timing();
        int e0;
        int t0;
        int f1;
        int f2;
        e0 = errors;
        send(1'b1, 3'b000, lcg_next(), lcg_next(), 6'd9);
        t0 = cyc;
        drain();
        check(fwd1_cyc == t0 + 3, "fwd1 not three cycles after issue");
        check(fwd2_cyc == t0 + 4, "fwd2 not four cycles after issue");
        check(cmp_cyc == t0 + 5, "complete not five cycles after issue");
        // Register 0 completes silently.
        f1 = fwd1_cyc;
        f2 = fwd2_cyc;
        send(1'b1, 3'b001, lcg_next(), lcg_next(), 6'd0);
        t0 = cyc;
        drain();
        check(cmp_cyc == t0 + 5, "complete for register 0 not five cycles after issue");
        check(fwd1_cyc == f1 && fwd2_cyc == f2, "forward tag raised for register 0");
        finish_test("single op timing", e0);
    endtask

    task automatic back_to_back();
        int  e0;
        int  n0;
        int  t0;
        logic op64;
        e0 = errors;
        n0 = cmp_count;
        t0 = -1;
        for (int i = 0; i < 24; i++) begin
            op64 = (i % 5 != 0);
            send(op64, op64 ? 3'(i % 4) : 3'b000, lcg_next(), lcg_next(), 6'(i % 7));
            if (i == 0) begin
                t0 = cyc;
            end
        end
        drain();
        check(cmp_count - n0 == 24, "back-to-back ops lost or duplicated");
        check(cmp_cyc == t0 + 5 + 23, "back-to-back results not one per cycle");
        finish_test("back to back", e0);
    endtask

    task automatic flush_and_divide();
        int e0;
        int n0;
        e0 = errors;
        n0 = cmp_count;
        for (int i = 0; i < 4; i++) begin
            send(1'b1, 3'b000, lcg_next(), lcg_next(), 6'(i + 1));
        end
        // Fifth op shares its cycle with the flush.
        send(1'b1, 3'b011, lcg_next(), lcg_next(), 6'd5);
        flush = 1'b1;
        idle();
        repeat (DEPTH + 1) @(negedge clk);
        check(cmp_count == n0, "flushed op completed");
        n0 = cmp_count;
        send(1'b1, 3'b001, CORNERS[3], CORNERS[2], 6'd6);
        send(1'b1, 3'b100, lcg_next(), lcg_next(), 6'd7);
        send(1'b0, 3'b000, lcg_next(), lcg_next(), 6'd8);
        drain();
        repeat (DEPTH + 1) @(negedge clk);
        check(cmp_count - n0 == 2, "divide encoding completed or op lost after flush");
        finish_test("flush and divide", e0);
    endtask

    initial begin
        int n;
        issue     = '0;
        flush     = 1'b0;
        lcg_state = 64'd48;
        next_iid  = '0;
        n = 0;
        while (!rst_clk && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rst_clk) begin
            hung     = 1'b1;
            hang_msg = "reset was never released";
        end
        check(!complete && !wb.vld && !fwd1.vld && !fwd2.vld, "valid output high after reset");
        if (!hung) mul_random_corners();
        if (!hung) mulh_signedness();
        if (!hung) mulw_upper_garbage();
        if (!hung) single_op_timing();
        if (!hung) back_to_back();
        if (!hung) flush_and_divide();
        if (hung) begin
            $display("Run stopped early: %s", hang_msg);
        end
        $display("Summary: %0d tests run, %0d errors", tests, errors);
        if (errors == 0 && !hung) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/mul_pkg.sv
design/mul_stage_reg.sv
design/mul_operand_stage.sv
design/mul_booth_stage.sv
design/mul_csa_tree_stage.sv
design/mul_final_add_stage.sv
design/mul_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mul_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mul_top
FLIST     ?= files.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST)) design/mul_defines.svh

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)
